// File: Bender.yml
package:
  name: rx_emu

sources:
  - rx_emu_geom_pkg.sv
  - rx_emu_regmap_pkg.sv
  - apb_config_regs.sv
  - frame_sequencer.sv
  - chunk_counter.sv
  - symbol_history.sv
  - slice_accumulator.sv
  - rx_emu_top.sv
  - target: test
    files:
      - tb_rx_emu.sv

// File: apb_config_regs.sv
`timescale 1ns/10ps

module apb_config_regs (
    input  logic                                                emu_clk,
    input  logic                                                emu_rst,
    input  logic                                                psel_i,
    input  logic                                                penable_i,
    input  logic                                                pwrite_i,
    input  logic [rx_emu_regmap_pkg::APB_ADDR_WIDTH-1:0]        paddr_i,
    input  logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0]        pwdata_i,
    output logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0]        prdata_o,
    output logic                                                pready_o,
    output logic                                                pslverr_o,
    output logic                                                enable_o,
    output logic [rx_emu_geom_pkg::SHIFT_WIDTH-1:0]             out_shift_o,
    output logic [rx_emu_geom_pkg::NUM_SLICES-1:0]              tap_we_o,
    output logic [rx_emu_geom_pkg::TAP_IDX_WIDTH-1:0]           tap_idx_o,
    output logic signed [rx_emu_geom_pkg::TAP_WIDTH-1:0]        tap_wdata_o
);

    rx_emu_regmap_pkg::apb_region_e                  region;
    logic [rx_emu_regmap_pkg::APB_ADDR_WIDTH-1:0]    tap_off;
    logic [rx_emu_geom_pkg::SLICE_IDX_WIDTH-1:0]     tap_slice;
    logic                                            access;
    logic                                            ctrl_wr;
    logic                                            tap_wr;

    // address decode
    always_comb begin
        if (paddr_i[rx_emu_regmap_pkg::APB_ADDR_WIDTH-1:2] ==
            rx_emu_regmap_pkg::CTRL_ADDR[rx_emu_regmap_pkg::APB_ADDR_WIDTH-1:2]) begin
            region = rx_emu_regmap_pkg::REGION_CTRL;
        end else if (paddr_i >= rx_emu_regmap_pkg::TAP_BASE &&
                     paddr_i <= rx_emu_regmap_pkg::TAP_LAST) begin
            region = rx_emu_regmap_pkg::REGION_TAP;
        end else begin
            region = rx_emu_regmap_pkg::REGION_NONE;
        end
    end

    assign tap_off   = paddr_i - rx_emu_regmap_pkg::TAP_BASE;
    assign tap_slice = tap_off[rx_emu_regmap_pkg::TAP_SLICE_LSB +:
                               rx_emu_geom_pkg::SLICE_IDX_WIDTH];

    assign access  = psel_i && penable_i;           // zero wait states
    assign ctrl_wr = access && pwrite_i && (region == rx_emu_regmap_pkg::REGION_CTRL);
    assign tap_wr  = access && pwrite_i && (region == rx_emu_regmap_pkg::REGION_TAP);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            enable_o    <= 1'b0;
            out_shift_o <= '0;
        end else if (ctrl_wr) begin
            enable_o    <= pwdata_i[rx_emu_regmap_pkg::CTRL_EN_BIT];
            out_shift_o <= pwdata_i[rx_emu_regmap_pkg::CTRL_SHIFT_LSB +:
                                    rx_emu_geom_pkg::SHIFT_WIDTH];
        end
    end

    // tap writes go straight to the slice memories on the access edge
    always_comb begin
        for (int s = 0; s < rx_emu_geom_pkg::NUM_SLICES; s++) begin
            tap_we_o[s] = tap_wr && (tap_slice == s);
        end
    end

    assign tap_idx_o   = tap_off[rx_emu_regmap_pkg::TAP_IDX_LSB +:
                                 rx_emu_geom_pkg::TAP_IDX_WIDTH];
    assign tap_wdata_o = pwdata_i[rx_emu_geom_pkg::TAP_WIDTH-1:0];

    // read mux, taps are write-only
    always_comb begin
        prdata_o = '0;
        if (region == rx_emu_regmap_pkg::REGION_CTRL) begin
            prdata_o[rx_emu_regmap_pkg::CTRL_EN_BIT] = enable_o;
            prdata_o[rx_emu_regmap_pkg::CTRL_SHIFT_LSB +:
                     rx_emu_geom_pkg::SHIFT_WIDTH] = out_shift_o;
        end
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access && (region == rx_emu_regmap_pkg::REGION_NONE);

endmodule

// File: chunk_counter.sv
`timescale 1ns/10ps

module chunk_counter (
    input  logic                                       emu_clk,
    input  logic                                       emu_rst,
    input  logic                                       cnt_start_i,
    input  logic                                       acc_en_i,
    output logic [rx_emu_geom_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx_o,
    output logic                                       last_chunk_o
);

    assign last_chunk_o = (chunk_idx_o == rx_emu_geom_pkg::NUM_CHUNKS - 1);

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            chunk_idx_o <= '0;
        end else if (cnt_start_i) begin
            chunk_idx_o <= '0;
        end else if (acc_en_i) begin
            // wrap after the final chunk of the frame
            if (last_chunk_o) begin
                chunk_idx_o <= '0;
            end else begin
                chunk_idx_o <= chunk_idx_o + 1'b1;
            end
        end else begin
            chunk_idx_o <= '0;                      // parked between frames
        end
    end

endmodule

// File: frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer (
    input  logic emu_clk,
    input  logic emu_rst,
    input  logic enable_i,
    input  logic sym_valid_i,
    input  logic last_chunk_i,
    output logic sym_ready_o,
    output logic hist_load_o,
    output logic cnt_start_o,
    output logic acc_clear_o,
    output logic acc_en_o,
    output logic emit_o,
    output logic adc_valid_o
);

    rx_emu_geom_pkg::frame_state_e state;
    rx_emu_geom_pkg::frame_state_e state_nxt;
    logic                          accept;

    assign sym_ready_o = (state == rx_emu_geom_pkg::LOAD);
    assign accept      = sym_ready_o && sym_valid_i;

    // a word accepted in LOAD starts the frame on the same edge
    assign hist_load_o = accept;
    assign cnt_start_o = accept;
    assign acc_clear_o = accept;
    assign acc_en_o    = (state == rx_emu_geom_pkg::ACCUM);
    assign emit_o      = (state == rx_emu_geom_pkg::EMIT);

    always_comb begin
        state_nxt = state;
        case (state)
            rx_emu_geom_pkg::IDLE: begin
                if (enable_i) state_nxt = rx_emu_geom_pkg::LOAD;
            end
            rx_emu_geom_pkg::LOAD: begin
                if (accept) state_nxt = rx_emu_geom_pkg::ACCUM;  // stalls here otherwise
            end
            rx_emu_geom_pkg::ACCUM: begin
                if (last_chunk_i) state_nxt = rx_emu_geom_pkg::EMIT;
            end
            rx_emu_geom_pkg::EMIT: begin
                // enable is only sampled between frames
                state_nxt = enable_i ? rx_emu_geom_pkg::LOAD : rx_emu_geom_pkg::IDLE;
            end
            default: state_nxt = rx_emu_geom_pkg::IDLE;
        endcase
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            state       <= rx_emu_geom_pkg::IDLE;
            adc_valid_o <= 1'b0;
        end else begin
            state       <= state_nxt;
            adc_valid_o <= emit_o;                  // slices register on the same edge
        end
    end

endmodule

// File: rx_emu.f
rx_emu_geom_pkg.sv
rx_emu_regmap_pkg.sv
apb_config_regs.sv
frame_sequencer.sv
chunk_counter.sv
symbol_history.sv
slice_accumulator.sv
rx_emu_top.sv
tb_rx_emu.sv

// File: rx_emu_geom_pkg.sv
package rx_emu_geom_pkg;

    // PAM4 symbol and history geometry
    localparam int BITS_PER_SYMBOL = 2;
    localparam int CHUNK_WIDTH     = 8;             // symbols per chunk
    localparam int NUM_CHUNKS      = 4;
    localparam int HIST_SYMBOLS    = CHUNK_WIDTH * NUM_CHUNKS;
    localparam int WORD_SYMBOLS    = 16;            // symbols per input word
    localparam int NUM_SLICES      = 4;             // interleaved sampling slices

    localparam int CHUNK_BITS      = CHUNK_WIDTH * BITS_PER_SYMBOL;
    localparam int WORD_BITS       = WORD_SYMBOLS * BITS_PER_SYMBOL;
    localparam int CHUNK_IDX_WIDTH = $clog2(NUM_CHUNKS);
    localparam int TAP_IDX_WIDTH   = $clog2(HIST_SYMBOLS);
    localparam int SLICE_IDX_WIDTH = $clog2(NUM_SLICES);

    // datapath widths
    localparam int TAP_WIDTH   = 10;                // signed tap
    localparam int ACC_WIDTH   = 18;                // signed accumulator
    localparam int ADC_WIDTH   = 8;                 // output magnitude
    localparam int SHIFT_WIDTH = 4;
    localparam int ADC_MAX     = (1 << ADC_WIDTH) - 1;

    // gray-free natural level code, -3 .. +3
    typedef enum logic [BITS_PER_SYMBOL-1:0] {
        SYM_M3 = 2'b00,
        SYM_M1 = 2'b01,
        SYM_P1 = 2'b10,
        SYM_P3 = 2'b11
    } sym_code_e;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        ACCUM,
        EMIT
    } frame_state_e;

endpackage

// File: rx_emu_regmap_pkg.sv
package rx_emu_regmap_pkg;

    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    // control register
    localparam logic [APB_ADDR_WIDTH-1:0] CTRL_ADDR = 12'h000;
    localparam int CTRL_EN_BIT    = 0;              // frame enable
    localparam int CTRL_SHIFT_LSB = 1;              // out_shift in bits 4:1

    // tap window, one word per tap, 32 taps per slice
    localparam logic [APB_ADDR_WIDTH-1:0] TAP_BASE = 12'h100;
    localparam logic [APB_ADDR_WIDTH-1:0] TAP_LAST = 12'h2fc;

    // field positions within the offset from TAP_BASE
    localparam int TAP_SLICE_LSB = 7;               // bits 8:7 select the slice
    localparam int TAP_IDX_LSB   = 2;               // bits 6:2 select the tap

    typedef enum logic [1:0] {
        REGION_CTRL,
        REGION_TAP,
        REGION_NONE
    } apb_region_e;

endpackage

// File: rx_emu_top.sv
`timescale 1ns/10ps

module rx_emu_top (
    input  logic                                                emu_clk,
    input  logic                                                emu_rst,
    input  logic                                                psel_i,
    input  logic                                                penable_i,
    input  logic                                                pwrite_i,
    input  logic [rx_emu_regmap_pkg::APB_ADDR_WIDTH-1:0]        paddr_i,
    input  logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0]        pwdata_i,
    output logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0]        prdata_o,
    output logic                                                pready_o,
    output logic                                                pslverr_o,
    input  logic [rx_emu_geom_pkg::WORD_BITS-1:0]               sym_word_i,
    input  logic                                                sym_valid_i,
    output logic                                                sym_ready_o,
    output logic                                                adc_valid_o,
    output logic [rx_emu_geom_pkg::NUM_SLICES-1:0]              adc_sgn_o,
    output logic [rx_emu_geom_pkg::NUM_SLICES-1:0][rx_emu_geom_pkg::ADC_WIDTH-1:0] adc_mag_o
);

    logic                                         enable;
    logic [rx_emu_geom_pkg::SHIFT_WIDTH-1:0]      out_shift;
    logic [rx_emu_geom_pkg::NUM_SLICES-1:0]       tap_we;
    logic [rx_emu_geom_pkg::TAP_IDX_WIDTH-1:0]    tap_idx;
    logic signed [rx_emu_geom_pkg::TAP_WIDTH-1:0] tap_wdata;

    logic hist_load;
    logic cnt_start;
    logic acc_clear;
    logic acc_en;
    logic emit;
    logic last_chunk;

    logic [rx_emu_geom_pkg::CHUNK_IDX_WIDTH-1:0]  chunk_idx;
    logic [rx_emu_geom_pkg::CHUNK_BITS-1:0]       chunk_syms;

    apb_config_regs u_apb (
        .emu_clk     (emu_clk),
        .emu_rst     (emu_rst),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .enable_o    (enable),
        .out_shift_o (out_shift),
        .tap_we_o    (tap_we),
        .tap_idx_o   (tap_idx),
        .tap_wdata_o (tap_wdata)
    );

    frame_sequencer u_seq (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .enable_i     (enable),
        .sym_valid_i  (sym_valid_i),
        .last_chunk_i (last_chunk),
        .sym_ready_o  (sym_ready_o),
        .hist_load_o  (hist_load),
        .cnt_start_o  (cnt_start),
        .acc_clear_o  (acc_clear),
        .acc_en_o     (acc_en),
        .emit_o       (emit),
        .adc_valid_o  (adc_valid_o)
    );

    chunk_counter u_cnt (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .cnt_start_i  (cnt_start),
        .acc_en_i     (acc_en),
        .chunk_idx_o  (chunk_idx),
        .last_chunk_o (last_chunk)
    );

    symbol_history u_hist (
        .emu_clk      (emu_clk),
        .emu_rst      (emu_rst),
        .hist_load_i  (hist_load),
        .sym_word_i   (sym_word_i),
        .chunk_idx_i  (chunk_idx),
        .chunk_syms_o (chunk_syms)
    );

    // all slices see the same chunk, each with its own taps
    for (genvar s = 0; s < rx_emu_geom_pkg::NUM_SLICES; s++) begin : gen_slice
        slice_accumulator u_slice (
            .emu_clk      (emu_clk),
            .emu_rst      (emu_rst),
            .tap_we_i     (tap_we[s]),
            .tap_idx_i    (tap_idx),
            .tap_wdata_i  (tap_wdata),
            .chunk_syms_i (chunk_syms),
            .chunk_idx_i  (chunk_idx),
            .acc_clear_i  (acc_clear),
            .acc_en_i     (acc_en),
            .emit_i       (emit),
            .out_shift_i  (out_shift),
            .adc_sgn_o    (adc_sgn_o[s]),
            .adc_mag_o    (adc_mag_o[s])
        );
    end

endmodule

// File: slice_accumulator.sv
`timescale 1ns/10ps

module slice_accumulator (
    input  logic                                        emu_clk,
    input  logic                                        emu_rst,
    input  logic                                        tap_we_i,
    input  logic [rx_emu_geom_pkg::TAP_IDX_WIDTH-1:0]   tap_idx_i,
    input  logic signed [rx_emu_geom_pkg::TAP_WIDTH-1:0] tap_wdata_i,
    input  logic [rx_emu_geom_pkg::CHUNK_BITS-1:0]      chunk_syms_i,
    input  logic [rx_emu_geom_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx_i,
    input  logic                                        acc_clear_i,
    input  logic                                        acc_en_i,
    input  logic                                        emit_i,
    input  logic [rx_emu_geom_pkg::SHIFT_WIDTH-1:0]     out_shift_i,
    output logic                                        adc_sgn_o,
    output logic [rx_emu_geom_pkg::ADC_WIDTH-1:0]       adc_mag_o
);

    localparam int B  = rx_emu_geom_pkg::BITS_PER_SYMBOL;
    localparam int CW = rx_emu_geom_pkg::CHUNK_WIDTH;
    localparam int AW = rx_emu_geom_pkg::ACC_WIDTH;

    logic signed [rx_emu_geom_pkg::TAP_WIDTH-1:0] taps [rx_emu_geom_pkg::HIST_SYMBOLS];
    logic signed [AW-1:0] tap_ext [CW];
    logic signed [AW-1:0] lvl_ext [CW];
    logic signed [AW-1:0] chunk_sum;
    logic signed [AW-1:0] acc;
    logic signed [AW-1:0] shifted;
    logic signed [AW-1:0] abs_val;

    // pulse response memory, one tap per history symbol
    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            for (int t = 0; t < rx_emu_geom_pkg::HIST_SYMBOLS; t++) begin
                taps[t] <= '0;
            end
        end else if (tap_we_i) begin
            taps[tap_idx_i] <= tap_wdata_i;
        end
    end

    for (genvar i = 0; i < CW; i++) begin : gen_lane
        // tap for history symbol chunk_idx*CW + i, sign extended
        assign tap_ext[i] = taps[chunk_idx_i*CW + i];

        always_comb begin
            case (rx_emu_geom_pkg::sym_code_e'(chunk_syms_i[i*B +: B]))
                rx_emu_geom_pkg::SYM_M3: lvl_ext[i] = -3;
                rx_emu_geom_pkg::SYM_M1: lvl_ext[i] = -1;
                rx_emu_geom_pkg::SYM_P1: lvl_ext[i] = 1;
                default:                 lvl_ext[i] = 3;
            endcase
        end
    end

    // eight products per emulator cycle
    always_comb begin
        chunk_sum = '0;
        for (int i = 0; i < CW; i++) begin
            chunk_sum = chunk_sum + tap_ext[i] * lvl_ext[i];
        end
    end

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            acc <= '0;
        end else if (acc_clear_i) begin
            acc <= '0;
        end else if (acc_en_i) begin
            acc <= acc + chunk_sum;
        end
    end

    // output scaling, sign-magnitude with saturation
    assign shifted = acc >>> out_shift_i;
    assign abs_val = shifted[AW-1] ? -shifted : shifted;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            adc_sgn_o <= 1'b0;
            adc_mag_o <= '0;
        end else if (emit_i) begin
            adc_sgn_o <= shifted[AW-1];
            if (abs_val > rx_emu_geom_pkg::ADC_MAX) begin
                adc_mag_o <= '1;                    // clip at full scale
            end else begin
                adc_mag_o <= abs_val[rx_emu_geom_pkg::ADC_WIDTH-1:0];
            end
        end
    end

endmodule

// File: symbol_history.sv
`timescale 1ns/10ps

module symbol_history (
    input  logic                                        emu_clk,
    input  logic                                        emu_rst,
    input  logic                                        hist_load_i,
    input  logic [rx_emu_geom_pkg::WORD_BITS-1:0]       sym_word_i,
    input  logic [rx_emu_geom_pkg::CHUNK_IDX_WIDTH-1:0] chunk_idx_i,
    output logic [rx_emu_geom_pkg::CHUNK_BITS-1:0]      chunk_syms_o
);

    localparam int B = rx_emu_geom_pkg::BITS_PER_SYMBOL;
    localparam int W = rx_emu_geom_pkg::WORD_SYMBOLS;

    logic [rx_emu_geom_pkg::WORD_BITS-1:0]          cur_word;
    logic [rx_emu_geom_pkg::WORD_BITS-1:0]          prev_word;
    logic [rx_emu_geom_pkg::HIST_SYMBOLS*B-1:0]     hist;

    always_ff @(posedge emu_clk) begin
        if (emu_rst) begin
            cur_word  <= '0;
            prev_word <= '0;
        end else if (hist_load_i) begin
            prev_word <= cur_word;
            cur_word  <= sym_word_i;
        end
    end

    // history symbol 0 is the newest, i.e. the top symbol of the newest word
    always_comb begin
        for (int k = 0; k < W; k++) begin
            hist[k*B +: B]     = cur_word[(W-1-k)*B +: B];
            hist[(k+W)*B +: B] = prev_word[(W-1-k)*B +: B];
        end
    end

    assign chunk_syms_o = hist[chunk_idx_i*rx_emu_geom_pkg::CHUNK_BITS +:
                               rx_emu_geom_pkg::CHUNK_BITS];

endmodule

// File: tb_rx_emu.sv
`timescale 1ns/10ps

module tb_rx_emu;

    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 16;
    localparam int IDLE_CYCLES  = 20;
    localparam int STALL_CYCLES = 3;
    localparam int NUM_ROWS     = 12;
    localparam int LAT_LIMIT    = 50;
    localparam int NC           = rx_emu_geom_pkg::NUM_CHUNKS;
    localparam int TAP_WRITES   = rx_emu_geom_pkg::NUM_SLICES * rx_emu_geom_pkg::HIST_SYMBOLS;
    localparam int CFG_CYCLES   = RST_CYCLES + IDLE_CYCLES + 3 * TAP_WRITES * 2 + 64;
    localparam int WATCHDOG_NS  = 2 * (NUM_ROWS * (NC + 2 + STALL_CYCLES) + CFG_CYCLES)
                                  * CLK_PERIOD;

    typedef struct packed {
        logic [rx_emu_geom_pkg::WORD_BITS-1:0]   word;
        logic                                    stall;    // hold valid low first
        logic [rx_emu_geom_pkg::SHIFT_WIDTH-1:0] shift;
        logic                                    drop_en;  // clear enable mid-frame
    } row_t;

    logic emu_clk = 1'b0;
    logic emu_rst;
    logic psel, penable, pwrite, pready, pslverr;
    logic [rx_emu_regmap_pkg::APB_ADDR_WIDTH-1:0] paddr;
    logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0] pwdata, prdata, rd_data;
    logic [rx_emu_geom_pkg::WORD_BITS-1:0]        sym_word, hist_cur, hist_prev;
    logic sym_valid, sym_ready, adc_valid, err;
    logic [rx_emu_geom_pkg::NUM_SLICES-1:0]       adc_sgn;
    logic [rx_emu_geom_pkg::NUM_SLICES-1:0][rx_emu_geom_pkg::ADC_WIDTH-1:0] adc_mag;
    logic [rx_emu_geom_pkg::SHIFT_WIDTH-1:0]      cur_shift;
    logic [31:0] lfsr_state = 32'h2867;
    row_t        stim [NUM_ROWS];
    int          tap_m [rx_emu_geom_pkg::NUM_SLICES][rx_emu_geom_pkg::HIST_SYMBOLS];
    int          errors = 0, checks = 0, tests = 0, test_base = 0;

    rx_emu_top u_dut (
        .emu_clk(emu_clk), .emu_rst(emu_rst),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
        .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
        .sym_word_i(sym_word), .sym_valid_i(sym_valid), .sym_ready_o(sym_ready),
        .adc_valid_o(adc_valid), .adc_sgn_o(adc_sgn), .adc_mag_o(adc_mag)
    );

    always #(CLK_PERIOD / 2) emu_clk = ~emu_clk;

    // fibonacci lfsr x^32+x^22+x^2+x+1 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int sym_level(input logic [1:0] code);
        case (code)
            2'b00:   return -3;
            2'b01:   return -1;
            2'b10:   return 1;
            default: return 3;
        endcase
    endfunction

    // convolution over the model history where symbol 0 is the newest
    function automatic int model_sum(input int s);
        int sum;
        sum = 0;
        for (int k = 0; k < 32; k++) begin
            if (k < 16) sum += tap_m[s][k] * sym_level(hist_cur[(15 - k) * 2 +: 2]);
            else        sum += tap_m[s][k] * sym_level(hist_prev[(31 - k) * 2 +: 2]);
        end
        return sum;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic en, input logic [3:0] shift);
        return {27'd0, shift, en};
    endfunction

    task automatic flag_error(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic check_mag(input string name, input logic [rx_emu_geom_pkg::ADC_WIDTH-1:0] exp,
                             input logic [rx_emu_geom_pkg::ADC_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_sgn(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0b got %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_apb_data(input string name,
                                  input logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0] exp,
                                  input logic [rx_emu_regmap_pkg::APB_DATA_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: prdata_o (%s) expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_pslverr(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: pslverr_o (%s) expected %0b got %0b",
                     $time, name, exp, act);
        end
    endtask

    task automatic check_pready(input string name, input logic act);
        checks++;
        if (act !== 1'b1) begin
            errors++;
            $display("Mismatch at %0t ns: pready_o (%s) expected 1 got %0b", $time, name, act);
        end
    endtask

    task automatic check_latency(input int act);
        checks++;
        if (act != NC + 1) begin
            errors++;
            $display("Mismatch at %0t ns: adc_valid_o latency expected %0d got %0d",
                     $time, NC + 1, act);
        end
    endtask

    // both apb tasks start and end on a falling edge
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic e);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge emu_clk) penable = 1'b1;
        #1 e = pslverr;                             // sampled before the access edge
        check_pready("write", pready);
        @(negedge emu_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic e);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        @(negedge emu_clk) penable = 1'b1;
        #1;
        data = prdata;
        e    = pslverr;
        check_pready("read", pready);
        @(negedge emu_clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_taps(input logic use_rand, input int value);
        logic [11:0] addr;
        logic [31:0] rnd;
        logic        e;
        for (int s = 0; s < rx_emu_geom_pkg::NUM_SLICES; s++) begin
            for (int k = 0; k < rx_emu_geom_pkg::HIST_SYMBOLS; k++) begin
                if (use_rand) begin
                    rnd         = take_bits(10);
                    tap_m[s][k] = int'($signed(rnd[9:0]));
                end else begin
                    tap_m[s][k] = value;
                end
                addr = rx_emu_regmap_pkg::TAP_BASE + 12'((s << 7) + (k << 2));
                apb_write(addr, 32'(tap_m[s][k]), e);
                check_pslverr("tap write", 1'b0, e);
            end
        end
    endtask

    task automatic wait_for_valid(output int lat);
        lat = 0;
        while (!adc_valid && lat < LAT_LIMIT) begin
            if (sym_ready) flag_error("sym_ready_o high while a frame was in flight");
            @(negedge emu_clk);
            lat++;
        end
    endtask

    task automatic run_frame(input row_t r);
        int   waited;
        int   lat;
        int   sh;
        int   mag;
        logic e;
        if (r.stall) begin
            repeat (STALL_CYCLES) begin
                @(negedge emu_clk);
                if (!sym_ready) flag_error("sym_ready_o dropped while waiting for a word");
            end
        end
        sym_word  = r.word;
        sym_valid = 1'b1;
        waited    = 0;
        while (!sym_ready && waited < LAT_LIMIT) begin
            @(negedge emu_clk);
            waited++;
        end
        if (!sym_ready) begin
            flag_error("sym_ready_o never rose for a pending word");
            sym_valid = 1'b0;
            return;
        end
        @(posedge emu_clk);                         // accepting edge
        hist_prev = hist_cur;
        hist_cur  = r.word;
        @(negedge emu_clk) sym_valid = 1'b0;
        if (r.drop_en) begin
            fork
                apb_write(rx_emu_regmap_pkg::CTRL_ADDR, ctrl_word(1'b0, r.shift), e);
                wait_for_valid(lat);
            join
            check_pslverr("ctrl write", 1'b0, e);
        end else begin
            wait_for_valid(lat);
        end
        if (!adc_valid) begin
            flag_error("adc_valid_o never rose after an accepted word");
            return;
        end
        check_latency(lat);
        for (int s = 0; s < rx_emu_geom_pkg::NUM_SLICES; s++) begin
            sh  = model_sum(s) >>> r.shift;
            mag = (sh < 0) ? -sh : sh;
            if (mag > 255) mag = 255;
            check_sgn($sformatf("adc_sgn_o[%0d]", s), sh < 0, adc_sgn[s]);
            check_mag($sformatf("adc_mag_o[%0d]", s), 8'(mag), adc_mag[s]);
        end
    endtask

    task automatic run_rows(input int first, input int last);
        logic e;
        for (int i = first; i <= last; i++) begin
            if (stim[i].shift != cur_shift) begin
                apb_write(rx_emu_regmap_pkg::CTRL_ADDR, ctrl_word(1'b1, stim[i].shift), e);
                check_pslverr("ctrl write", 1'b0, e);
                cur_shift = stim[i].shift;
            end
            run_frame(stim[i]);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_base) $display("test %s: ok", name);
        else $display("test %s: failed with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        emu_rst   = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        sym_word  = '0;
        sym_valid = 1'b0;
        hist_cur  = '0;
        hist_prev = '0;
        cur_shift = '0;
        // random rows first and saturating rows of all +3 symbols after
        stim[0]  = '{32'h1b4e_92c7, 1'b0, 4'd0, 1'b0};
        stim[1]  = '{32'hd03a_6f15, 1'b0, 4'd0, 1'b0};
        stim[2]  = '{32'h7c91_e4a8, 1'b1, 4'd0, 1'b0};
        stim[3]  = '{32'h0000_0000, 1'b0, 4'd0, 1'b0};
        stim[4]  = '{32'ha5f3_28bd, 1'b1, 4'd0, 1'b0};
        stim[5]  = '{32'h4e6d_b907, 1'b0, 4'd0, 1'b0};
        stim[6]  = '{32'hffff_ffff, 1'b0, 4'd0, 1'b0};
        stim[7]  = '{32'hffff_ffff, 1'b1, 4'd0, 1'b0};
        stim[8]  = '{32'hffff_ffff, 1'b0, 4'd8, 1'b0};
        stim[9]  = '{32'hffff_ffff, 1'b0, 4'd0, 1'b0};
        stim[10] = '{32'hffff_ffff, 1'b0, 4'd10, 1'b0};
        stim[11] = '{32'h39c2_5ae1, 1'b0, 4'd0, 1'b1};
        repeat (RST_CYCLES) @(negedge emu_clk);
        emu_rst = 1'b0;

        sym_valid = 1'b1;                           // offered but must be ignored
        repeat (IDLE_CYCLES) begin
            @(negedge emu_clk);
            if (adc_valid || sym_ready) flag_error("DUT active before enable was set");
        end
        sym_valid = 1'b0;
        end_test("idle_before_enable");

        load_taps(1'b1, 0);
        apb_write(rx_emu_regmap_pkg::CTRL_ADDR, 32'h1a, err);
        check_pslverr("ctrl write", 1'b0, err);
        apb_read(rx_emu_regmap_pkg::CTRL_ADDR, rd_data, err);
        check_apb_data("ctrl read", 32'h1a, rd_data);
        apb_read(rx_emu_regmap_pkg::TAP_BASE + 12'h004, rd_data, err);
        check_apb_data("tap read", 32'h0, rd_data);
        check_pslverr("tap read", 1'b0, err);
        apb_write(12'h400, 32'h1f, err);
        check_pslverr("unmapped write", 1'b1, err);
        apb_read(rx_emu_regmap_pkg::CTRL_ADDR, rd_data, err);
        check_apb_data("ctrl after unmapped write", 32'h1a, rd_data);
        apb_read(12'h800, rd_data, err);
        check_pslverr("unmapped read", 1'b1, err);
        end_test("register_access");

        apb_write(rx_emu_regmap_pkg::CTRL_ADDR, ctrl_word(1'b1, 4'd0), err);
        run_rows(0, 5);
        end_test("convolution");

        load_taps(1'b0, 511);
        run_rows(6, 8);
        load_taps(1'b0, -511);
        run_rows(9, 10);
        end_test("scaling_saturation");

        run_rows(11, 11);
        repeat (10) begin
            @(negedge emu_clk);
            if (sym_ready || adc_valid) flag_error("DUT kept running after enable was cleared");
        end
        end_test("enable_control");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
